//--- cpuDatapath.f
hdl/isaPkg.sv
hdl/datapathPkg.sv
hdl/busMux.sv
hdl/selectEncode.sv
hdl/regFile.sv
hdl/alu.sv
hdl/conFf.sv
hdl/memUnit.sv
hdl/cpuDatapath.sv
dv/clockGen.sv
dv/cpuDatapath_asserts.sv
dv/tbCpuDatapath.sv

//--- dv/tbCpuDatapath.sv
`timescale 1ns/100ps
`default_nettype none

module tbCpuDatapath;
    import isaPkg::*;
    import datapathPkg::*;

    localparam int periodNs        = 40;
    localparam int aluPairs        = 2;
    localparam int memWords        = 4;
    localparam int resetTestCycles = 16;
    localparam int transferCycles  = 50;
    localparam int aluCycles       = 13 * aluPairs * 5;
    localparam int memCycles       = memWords * 7;
    localparam int jalCycles       = 14;
    localparam int branchCycles    = 32;
    localparam int totalCycles     = resetTestCycles + transferCycles + aluCycles
                                   + memCycles + jalCycles + branchCycles;
    localparam int timeoutNs       = totalCycles * periodNs * 3 / 2;

    logic    clk;
    logic    rstN;
    logic    pcIn, irIn, yIn, zIn, hiIn, loIn, marIn, mdrIn, outPortIn, conIn;
    logic    incPc, pcOut, zHighOut, zLowOut, hiOut, loOut, mdrOut, inPortOut, cOut;
    logic    read, write;
    logic    gra, grb, grc, rIn, rOut, baOut;
    opcodeE  aluOp;
    regMaskT regInMan;
    regMaskT regOutMan;
    wordT    inPortData;
    wordT    outPortData;
    wordT    busData;
    wordT    pcData;
    logic    conFlag;

    int checkCount = 0;
    int errorCount = 0;

    clockGen #(.periodNs(periodNs)) clockGen_inst (.clk(clk));

    cpuDatapath #(.memDepth(512)) cpuDatapath_inst (.*);

    task automatic clearCtl();
        {pcIn, irIn, yIn, zIn, hiIn, loIn, marIn, mdrIn, outPortIn, conIn} = '0;
        {incPc, pcOut, zHighOut, zLowOut, hiOut, loOut, mdrOut, inPortOut, cOut} = '0;
        {read, write, gra, grb, grc, rIn, rOut, baOut} = '0;
        aluOp     = add;
        regInMan  = '0;
        regOutMan = '0;
    endtask

    // Strobes set at a falling edge take effect at the next rising edge
    task automatic endStep();
        @(posedge clk);
        @(negedge clk);
        clearCtl();
    endtask

    task automatic sampleBus(output wordT value);
        #(periodNs / 4);   // Well inside the low phase
        value = busData;
    endtask

    task automatic checkWord(input string what, input wordT got, input wordT expected);
        checkCount++;
        assert (got === expected) else begin
            errorCount++;
            $display("ERROR %0t ns: %s got %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic putIn(input wordT value);
        inPortData = value;   // In-port register picks it up at the next edge
        endStep();
    endtask

    task automatic inToReg(input int idx, input wordT value);
        putIn(value);
        inPortOut = 1'b1;
        regInMan  = regMaskT'(1) << idx;
        endStep();
    endtask

    task automatic readReg(input int idx, input logic ba, output wordT value);
        regOutMan = regMaskT'(1) << idx;
        baOut     = ba;
        sampleBus(value);
        endStep();
    endtask

    function automatic logic [63:0] expectAlu(input opcodeE op, input wordT a, input wordT b);
        logic [63:0] r;
        longint      sa;
        longint      sb;
        r  = 64'd0;
        sa = $signed(a);
        sb = $signed(b);
        case (op)
            ld, ldi, st, add, addi: r[31:0] = a + b;
            sub:   r[31:0] = a - b;
            shr:   r[31:0] = a >> (b % 32);
            shl:   r[31:0] = a << (b % 32);
            andOp: r[31:0] = a & b;
            orOp:  r[31:0] = a | b;
            mul:   r = sa * sb;
            neg:   r[31:0] = 32'd0 - b;
            notOp: r[31:0] = b ^ 32'hffff_ffff;
            default: r = 64'd0;
        endcase
        return r;
    endfunction

    task automatic resetValues();
        wordT got;
        checkWord("pcData after reset", pcData, '0);
        checkWord("outPortData after reset", outPortData, '0);
        checkWord("conFlag after reset", wordT'(conFlag), '0);
        for (int i = 0; i < regCount; i++) begin
            readReg(i, 1'b0, got);
            checkWord($sformatf("R%0d after reset", i), got, '0);
        end
    endtask

    task automatic registerTransfer();
        wordT vals [regCount];
        wordT got;
        for (int i = 0; i < regCount; i++) begin
            vals[i] = $urandom;
            inToReg(i, vals[i]);
            readReg(i, 1'b0, got);
            checkWord($sformatf("R%0d readback", i), got, vals[i]);
        end
        readReg(0, 1'b1, got);
        checkWord("R0 in base-address mode", got, '0);
        regOutMan = regMaskT'(1) << 5;
        outPortIn = 1'b1;
        endStep();
        checkWord("outPortData from R5", outPortData, vals[5]);
    endtask

    task automatic aluOperations();
        opcodeE      ops [13] = '{ld, ldi, st, add, sub, shr, shl, andOp, orOp, addi,
                                  mul, neg, notOp};
        wordT        a;
        wordT        b;
        wordT        got;
        logic [63:0] expected;
        for (int i = 0; i < 13; i++) begin
            for (int k = 0; k < aluPairs; k++) begin
                a = $urandom;
                b = $urandom;
                expected = expectAlu(ops[i], a, b);
                putIn(a);
                inPortOut  = 1'b1;
                yIn        = 1'b1;
                inPortData = b;   // Next operand, while a goes into Y
                endStep();
                inPortOut = 1'b1;
                zIn       = 1'b1;
                aluOp     = ops[i];
                endStep();
                zLowOut = 1'b1;
                sampleBus(got);
                endStep();
                checkWord($sformatf("%s low word", ops[i].name()), got, expected[31:0]);
                zHighOut = 1'b1;
                sampleBus(got);
                endStep();
                checkWord($sformatf("%s high word", ops[i].name()), got, expected[63:32]);
            end
        end
    endtask

    task automatic memoryRoundTrip();
        wordT addr;
        wordT data;
        wordT got;
        for (int i = 0; i < memWords; i++) begin
            addr = $urandom;   // Upper bits are ignored by the RAM
            data = $urandom;
            putIn(addr);
            inPortOut  = 1'b1;
            marIn      = 1'b1;
            inPortData = data;
            endStep();
            inPortOut = 1'b1;
            mdrIn     = 1'b1;
            endStep();
            write      = 1'b1;
            inPortData = ~data;
            endStep();
            inPortOut = 1'b1;   // Clobber MDR so only the RAM read can restore it
            mdrIn     = 1'b1;
            endStep();
            read  = 1'b1;
            mdrIn = 1'b1;
            endStep();
            mdrOut = 1'b1;
            sampleBus(got);
            endStep();
            checkWord($sformatf("memory word at %h", addr), got, data);
        end
    endtask

    task automatic jalSequence();
        wordT got;
        inToReg(2, 32'd240);
        putIn(32'd0);
        inPortOut  = 1'b1;
        marIn      = 1'b1;
        inPortData = 32'ha900_0000;   // jal R2
        endStep();
        inPortOut  = 1'b1;
        mdrIn      = 1'b1;
        inPortData = 32'd0;
        endStep();
        write = 1'b1;
        endStep();
        inPortOut = 1'b1;
        pcIn      = 1'b1;
        endStep();
        pcOut = 1'b1;   // T0
        incPc = 1'b1;
        marIn = 1'b1;
        zIn   = 1'b1;
        endStep();
        zLowOut = 1'b1;   // T1
        pcIn    = 1'b1;
        read    = 1'b1;
        mdrIn   = 1'b1;
        endStep();
        mdrOut = 1'b1;   // T2
        irIn   = 1'b1;
        endStep();
        checkWord("PC after fetch", pcData, 32'd1);
        pcOut    = 1'b1;   // T3 link
        regInMan = regMaskT'(1) << 15;
        endStep();
        gra  = 1'b1;   // T4 jump to R2
        rOut = 1'b1;
        pcIn = 1'b1;
        endStep();
        checkWord("PC after jal", pcData, 32'd240);
        readReg(15, 1'b0, got);
        checkWord("R15 link value", got, 32'd1);
    endtask

    task automatic branchConditions();
        wordT values [3];
        wordT ir;
        logic expFlag;
        for (int c = 0; c < 4; c++) begin
            ir = {br, 4'd3, 2'b00, c[1:0], 19'd0};
            values[0] = 32'd0;
            values[1] = ($urandom & 32'h7fff_ffff) | 32'd1;
            values[2] = $urandom | 32'h8000_0000;
            putIn(ir);
            inPortOut = 1'b1;
            irIn      = 1'b1;
            endStep();
            for (int k = 0; k < 3; k++) begin
                case (c)
                    0:       expFlag = (values[k] == 32'd0);
                    1:       expFlag = (values[k] != 32'd0);
                    2:       expFlag = !values[k][31];
                    default: expFlag = values[k][31];
                endcase
                putIn(values[k]);
                inPortOut = 1'b1;
                conIn     = 1'b1;
                endStep();
                checkWord($sformatf("conFlag for C2 %0d, bus %h", c, values[k]),
                          wordT'(conFlag), wordT'(expFlag));
            end
        end
    endtask

    task automatic runWatchdog();
        #(timeoutNs);
        $display("Timeout: tests did not finish within %0d ns", timeoutNs);
        $display("sim failed");
        $finish;
    endtask

    initial begin
        void'($urandom(32'hcfe5));
        clearCtl();
        inPortData = '0;
        rstN       = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        fork
            runWatchdog();
        join_none
        resetValues();
        registerTransfer();
        aluOperations();
        memoryRoundTrip();
        jalSequence();
        branchConditions();
        $display("Checks %0d, errors %0d, assertion failures %0d", checkCount, errorCount,
                 cpuDatapath_inst.cpuDatapathAsserts_inst.failCount);
        if (errorCount == 0 && cpuDatapath_inst.cpuDatapathAsserts_inst.failCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/cpuDatapath_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module cpuDatapathAsserts (
    input logic                 clk,
    input logic                 rstN,
    input logic                 pcIn,
    input logic                 irIn,
    input logic                 yIn,
    input logic                 zIn,
    input logic                 hiIn,
    input logic                 loIn,
    input logic                 marIn,
    input logic                 mdrIn,
    input logic                 outPortIn,
    input logic                 conIn,
    input logic                 incPc,
    input logic                 pcOut,
    input logic                 zHighOut,
    input logic                 zLowOut,
    input logic                 hiOut,
    input logic                 loOut,
    input logic                 mdrOut,
    input logic                 inPortOut,
    input logic                 cOut,
    input logic                 read,
    input logic                 write,
    input logic                 rIn,
    input logic                 rOut,
    input datapathPkg::regMaskT regInMan,
    input datapathPkg::regMaskT regOutMan,
    input datapathPkg::wordT    pcData,
    input datapathPkg::wordT    outPortData,
    input logic                 conFlag
);

    logic       busTaken;
    logic [8:0] busSources;
    int         failCount = 0;

    // Any unit that loads from the bus on the coming edge
    assign busTaken = pcIn | irIn | yIn | zIn | hiIn | loIn | marIn | (mdrIn & ~read)
                    | outPortIn | conIn | rIn | (|regInMan);

    // incPc puts PC on the bus just like pcOut
    assign busSources = {pcOut | incPc, zHighOut, zLowOut, hiOut, loOut, mdrOut,
                         inPortOut, cOut, rOut | (|regOutMan)};

    resetZero: assert property (@(posedge clk)
        !rstN |-> (pcData == '0 && outPortData == '0 && !conFlag))
        else begin
            $error("Datapath state is not zero while reset is held");
            failCount++;
        end

    oneSource: assert property (@(posedge clk) disable iff (!rstN)
        busTaken |-> $countones(busSources) <= 1)
        else begin
            $error("More than one unit drives the bus while it is loaded");
            failCount++;
        end

    noReadWrite: assert property (@(posedge clk) disable iff (!rstN)
        !(read && write))
        else begin
            $error("Memory read and write are high together");
            failCount++;
        end

endmodule

bind cpuDatapath cpuDatapathAsserts cpuDatapathAsserts_inst (.*);

`default_nettype wire

//--- dv/clockGen.sv
`timescale 1ns/100ps
`default_nettype none

module clockGen #(
    parameter int periodNs = 40
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(periodNs / 2) clk = ~clk;   // 50 % duty cycle

endmodule

`default_nettype wire

//--- hdl/cpuDatapath.sv
`timescale 1ns/100ps
`default_nettype none

module cpuDatapath #(
    parameter int memDepth = 512
) (
    input  logic                    clk,
    input  logic                    rstN,
    // Register load strobes
    input  logic                    pcIn,
    input  logic                    irIn,
    input  logic                    yIn,
    input  logic                    zIn,
    input  logic                    hiIn,
    input  logic                    loIn,
    input  logic                    marIn,
    input  logic                    mdrIn,
    input  logic                    outPortIn,
    input  logic                    conIn,
    // Bus drive strobes
    input  logic                    incPc,
    input  logic                    pcOut,
    input  logic                    zHighOut,
    input  logic                    zLowOut,
    input  logic                    hiOut,
    input  logic                    loOut,
    input  logic                    mdrOut,
    input  logic                    inPortOut,
    input  logic                    cOut,
    input  logic                    read,
    input  logic                    write,
    // Register select and encode
    input  logic                    gra,
    input  logic                    grb,
    input  logic                    grc,
    input  logic                    rIn,
    input  logic                    rOut,
    input  logic                    baOut,
    input  isaPkg::opcodeE          aluOp,
    input  datapathPkg::regMaskT    regInMan,
    input  datapathPkg::regMaskT    regOutMan,
    input  datapathPkg::wordT       inPortData,
    output datapathPkg::wordT       outPortData,
    output datapathPkg::wordT       busData,
    output datapathPkg::wordT       pcData,
    output logic                    conFlag
);
    import datapathPkg::*;

    wordT                   pcReg;
    wordT                   irReg;
    wordT                   yReg;
    logic [2*wordWidth-1:0] zReg;
    wordT                   hiReg;
    wordT                   loReg;
    wordT                   inPortReg;
    wordT                   regData;
    wordT                   mdrValue;
    regMaskT                writeMask;
    regIndexT               readIndex;
    logic                   regRead;
    logic [2*wordWidth-1:0] aluResult;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcReg       <= '0;
            irReg       <= '0;
            yReg        <= '0;
            zReg        <= '0;
            hiReg       <= '0;
            loReg       <= '0;
            inPortReg   <= '0;
            outPortData <= '0;
        end else begin
            inPortReg <= inPortData;   // Sampled every cycle
            if (pcIn)      pcReg       <= busData;
            if (irIn)      irReg       <= busData;
            if (yIn)       yReg        <= busData;
            if (zIn)       zReg        <= aluResult;
            if (hiIn)      hiReg       <= busData;
            if (loIn)      loReg       <= busData;
            if (outPortIn) outPortData <= busData;
        end
    end

    assign pcData = pcReg;

    busMux busMux_inst (
        .incPc      (incPc),
        .pcOut      (pcOut),
        .zHighOut   (zHighOut),
        .zLowOut    (zLowOut),
        .hiOut      (hiOut),
        .loOut      (loOut),
        .mdrOut     (mdrOut),
        .inPortOut  (inPortOut),
        .cOut       (cOut),
        .regRead    (regRead),
        .regData    (regData),
        .pcValue    (pcReg),
        .zHigh      (zReg[2*wordWidth-1:wordWidth]),
        .zLow       (zReg[wordWidth-1:0]),
        .hiValue    (hiReg),
        .loValue    (loReg),
        .mdrValue   (mdrValue),
        .inPortValue(inPortReg),
        .irValue    (irReg),
        .busData    (busData)
    );

    selectEncode selectEncode_inst (
        .irValue  (irReg),
        .gra      (gra),
        .grb      (grb),
        .grc      (grc),
        .rIn      (rIn),
        .rOut     (rOut),
        .regInMan (regInMan),
        .regOutMan(regOutMan),
        .writeMask(writeMask),
        .readIndex(readIndex),
        .regRead  (regRead)
    );

    regFile regFile_inst (
        .clk      (clk),
        .rstN     (rstN),
        .writeMask(writeMask),
        .readIndex(readIndex),
        .baOut    (baOut),
        .busData  (busData),
        .regData  (regData)
    );

    alu alu_inst (
        .opA   (yReg),
        .opB   (busData),
        .aluOp (aluOp),
        .incPc (incPc),
        .result(aluResult)
    );

    conFf conFf_inst (
        .clk    (clk),
        .rstN   (rstN),
        .conIn  (conIn),
        .irValue(irReg),
        .busData(busData),
        .conFlag(conFlag)
    );

    // MAR is only needed inside the memory unit for addressing
    memUnit #(
        .memDepth(memDepth)
    ) memUnit_inst (
        .clk     (clk),
        .rstN    (rstN),
        .busData (busData),
        .marIn   (marIn),
        .mdrIn   (mdrIn),
        .read    (read),
        .write   (write),
        .marValue(),
        .mdrValue(mdrValue)
    );

endmodule

`default_nettype wire

//--- hdl/memUnit.sv
`timescale 1ns/100ps
`default_nettype none

module memUnit #(
    parameter int memDepth = 512
) (
    input  logic              clk,
    input  logic              rstN,
    input  datapathPkg::wordT busData,
    input  logic              marIn,
    input  logic              mdrIn,
    input  logic              read,
    input  logic              write,
    output datapathPkg::wordT marValue,
    output datapathPkg::wordT mdrValue
);
    import datapathPkg::*;

    localparam int addrWidth = $clog2(memDepth);

    wordT                 ram [memDepth];
    wordT                 ramData;
    logic [addrWidth-1:0] addr;

    assign addr    = marValue[addrWidth-1:0];   // Upper MAR bits ignored
    assign ramData = ram[addr];                 // Asynchronous read

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            marValue <= '0;
            mdrValue <= '0;
        end else begin
            if (marIn) marValue <= busData;
            if (mdrIn) mdrValue <= read ? ramData : busData;
        end
    end

    always_ff @(posedge clk) begin
        if (write) ram[addr] <= mdrValue;
    end

endmodule

`default_nettype wire

//--- hdl/conFf.sv
`timescale 1ns/100ps
`default_nettype none

module conFf (
    input  logic              clk,
    input  logic              rstN,
    input  logic              conIn,
    input  datapathPkg::wordT irValue,
    input  datapathPkg::wordT busData,
    output logic              conFlag
);
    import isaPkg::*;

    branchCondE cond;
    logic       condMet;

    assign cond = branchCondE'(irValue[c2Msb:c2Lsb]);

    always_comb begin
        case (cond)
            brzr:    condMet = (busData == '0);
            brnz:    condMet = (busData != '0);
            brpl:    condMet = !busData[31];   // Zero counts as non-negative
            brmi:    condMet = busData[31];
            default: condMet = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)      conFlag <= 1'b0;
        else if (conIn) conFlag <= condMet;
    end

endmodule

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  datapathPkg::wordT                 opA,
    input  datapathPkg::wordT                 opB,
    input  isaPkg::opcodeE                    aluOp,
    input  logic                              incPc,
    output logic [2*datapathPkg::wordWidth-1:0] result
);
    import datapathPkg::*;
    import isaPkg::*;

    always_comb begin
        result = '0;   // High word stays zero except for mul
        if (incPc) begin
            result[wordWidth-1:0] = opB + 1'b1;
        end else begin
            case (aluOp)
                ld, ldi, st, add, addi:
                    result[wordWidth-1:0] = opA + opB;   // Address and immediate forms too
                sub:   result[wordWidth-1:0] = opA - opB;
                shr:   result[wordWidth-1:0] = opA >> opB[4:0];
                shl:   result[wordWidth-1:0] = opA << opB[4:0];
                andOp: result[wordWidth-1:0] = opA & opB;
                orOp:  result[wordWidth-1:0] = opA | opB;
                mul:   result = $signed(opA) * $signed(opB);   // Full signed product
                neg:   result[wordWidth-1:0] = -opB;
                notOp: result[wordWidth-1:0] = ~opB;
                default: result = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile (
    input  logic                  clk,
    input  logic                  rstN,
    input  datapathPkg::regMaskT  writeMask,
    input  datapathPkg::regIndexT readIndex,
    input  logic                  baOut,
    input  datapathPkg::wordT     busData,
    output datapathPkg::wordT     regData
);
    import datapathPkg::*;

    wordT regs [regCount];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) regs[i] <= '0;
        end else begin
            for (int i = 0; i < regCount; i++) begin
                if (writeMask[i]) regs[i] <= busData;
            end
        end
    end

    // R0 reads as zero in base-address mode
    assign regData = (baOut && readIndex == '0) ? '0 : regs[readIndex];

endmodule

`default_nettype wire

//--- hdl/selectEncode.sv
`timescale 1ns/100ps
`default_nettype none

module selectEncode (
    input  datapathPkg::wordT     irValue,
    input  logic                  gra,
    input  logic                  grb,
    input  logic                  grc,
    input  logic                  rIn,
    input  logic                  rOut,
    input  datapathPkg::regMaskT  regInMan,
    input  datapathPkg::regMaskT  regOutMan,
    output datapathPkg::regMaskT  writeMask,
    output datapathPkg::regIndexT readIndex,
    output logic                  regRead
);
    import datapathPkg::*;
    import isaPkg::*;

    regIndexT fieldIndex;
    regIndexT manIndex;

    always_comb begin
        if (gra)        fieldIndex = irValue[raMsb:raLsb];
        else if (grb)   fieldIndex = irValue[rbMsb:rbLsb];
        else if (grc)   fieldIndex = irValue[rcMsb:rcLsb];
        else            fieldIndex = '0;
    end

    // Scan down so the lowest set bit wins
    always_comb begin
        manIndex = '0;
        for (int i = regCount - 1; i >= 0; i--) begin
            if (regOutMan[i]) manIndex = regIndexT'(i);
        end
    end

    assign writeMask = regInMan | (regMaskT'(rIn) << fieldIndex);
    assign regRead   = rOut | (|regOutMan);
    assign readIndex = (|regOutMan) ? manIndex : fieldIndex;   // Manual mask has priority

endmodule

`default_nettype wire

//--- hdl/busMux.sv
`timescale 1ns/100ps
`default_nettype none

module busMux (
    input  logic              incPc,
    input  logic              pcOut,
    input  logic              zHighOut,
    input  logic              zLowOut,
    input  logic              hiOut,
    input  logic              loOut,
    input  logic              mdrOut,
    input  logic              inPortOut,
    input  logic              cOut,
    input  logic              regRead,
    input  datapathPkg::wordT regData,
    input  datapathPkg::wordT pcValue,
    input  datapathPkg::wordT zHigh,
    input  datapathPkg::wordT zLow,
    input  datapathPkg::wordT hiValue,
    input  datapathPkg::wordT loValue,
    input  datapathPkg::wordT mdrValue,
    input  datapathPkg::wordT inPortValue,
    input  datapathPkg::wordT irValue,
    output datapathPkg::wordT busData
);
    import datapathPkg::*;
    import isaPkg::*;

    busSrcE busSrc;
    wordT   constValue;

    // Fixed priority since only one strobe is expected at a time
    always_comb begin
        if (regRead)                busSrc = srcReg;
        else if (pcOut || incPc)    busSrc = srcPc;   // PC increment needs PC as operand B
        else if (zHighOut)          busSrc = srcZHigh;
        else if (zLowOut)           busSrc = srcZLow;
        else if (hiOut)             busSrc = srcHi;
        else if (loOut)             busSrc = srcLo;
        else if (mdrOut)            busSrc = srcMdr;
        else if (inPortOut)         busSrc = srcInPort;
        else if (cOut)              busSrc = srcConst;
        else                        busSrc = srcNone;
    end

    assign constValue = {{(wordWidth-cMsb-1){irValue[cMsb]}}, irValue[cMsb:cLsb]};

    always_comb begin
        case (busSrc)
            srcReg:    busData = regData;
            srcPc:     busData = pcValue;
            srcZHigh:  busData = zHigh;
            srcZLow:   busData = zLow;
            srcHi:     busData = hiValue;
            srcLo:     busData = loValue;
            srcMdr:    busData = mdrValue;
            srcInPort: busData = inPortValue;
            srcConst:  busData = constValue;
            default:   busData = '0;   // Idle bus
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/datapathPkg.sv
`default_nettype none

package datapathPkg;

    localparam int wordWidth = 32;
    localparam int regCount  = 16;

    typedef logic [wordWidth-1:0]         wordT;
    typedef logic [$clog2(regCount)-1:0]  regIndexT;
    typedef logic [regCount-1:0]          regMaskT;   // One-hot or zero

    // Which unit drives the shared bus
    typedef enum logic [3:0] {
        srcNone,
        srcReg,
        srcPc,
        srcZHigh,
        srcZLow,
        srcHi,
        srcLo,
        srcMdr,
        srcInPort,
        srcConst
    } busSrcE;

endpackage

`default_nettype wire

//--- hdl/isaPkg.sv
`default_nettype none

package isaPkg;

    // Opcode field values
    typedef enum logic [4:0] {
        ld    = 5'd0,
        ldi   = 5'd1,
        st    = 5'd2,
        add   = 5'd3,
        sub   = 5'd4,
        shr   = 5'd5,
        shl   = 5'd6,
        andOp = 5'd9,
        orOp  = 5'd10,
        addi  = 5'd11,
        mul   = 5'd14,
        neg   = 5'd16,
        notOp = 5'd17,
        br    = 5'd18,
        jr    = 5'd20,
        jal   = 5'd21,
        inOp  = 5'd22,
        outOp = 5'd23
    } opcodeE;

    // C2 field of a branch instruction
    typedef enum logic [1:0] {
        brzr,
        brnz,
        brpl,
        brmi
    } branchCondE;

    localparam int opMsb = 31;
    localparam int opLsb = 27;
    localparam int raMsb = 26;
    localparam int raLsb = 23;
    localparam int rbMsb = 22;
    localparam int rbLsb = 19;
    localparam int rcMsb = 18;
    localparam int rcLsb = 15;
    localparam int cMsb  = 18;   // Constant is sign-extended from here
    localparam int cLsb  = 0;
    localparam int c2Msb = 20;
    localparam int c2Lsb = 19;

endpackage

`default_nettype wire
